/* source/checker_pkg.sv */
package checker_pkg;

  // CSR window geometry
  localparam int csr_addr_width = 14;
  localparam int csr_data_width = 32;

  // Memory word and mode data
  localparam int word_width = 64;

  // Statistics counter widths
  localparam int stat_cpt_width = 16;
  localparam int stat_trn_width = 32;

  // Engine modes
  // SINGLE is the reset value
  typedef enum logic [1:0] {
    MODE_SINGLE = 2'd0,
    MODE_AUTO   = 2'd1,
    MODE_READ   = 2'd2,
    MODE_DUMMY  = 2'd3
  } checker_mode_e;

  // Controller run states
  typedef enum logic [1:0] {
    STATE_IDLE = 2'd0,
    STATE_RUN  = 2'd1,
    STATE_WAIT = 2'd2,
    STATE_ACK  = 2'd3
  } checker_state_e;

  // Register index in the low address bits
  typedef enum logic [2:0] {
    CSR_ADDRESS_LOW    = 3'd0,
    CSR_ADDRESS_HIGH   = 3'd1,
    CSR_STAT           = 3'd2,
    CSR_CTRL           = 3'd3,
    CSR_MODE_DATA_LOW  = 3'd4,
    CSR_MODE_DATA_HIGH = 3'd5,
    CSR_STAT_TRN_CPT   = 3'd6,
    CSR_STAT_TRN       = 3'd7
  } checker_csr_e;

endpackage

/* source/checker_ctlif.sv */
module checker_ctlif #(
  parameter logic [3:0] csr_addr = 4'h0
) (
  input  logic                                       sys_clk,
  input  logic                                       sys_rst,
  // CSR port
  input  logic [checker_pkg::csr_addr_width-1:0]     csr_a,
  input  logic                                       csr_we,
  input  logic [checker_pkg::csr_data_width-1:0]     csr_di,
  output logic [checker_pkg::csr_data_width-1:0]     csr_do,
  // Mode port towards the engine
  output checker_pkg::checker_mode_e                 mode_mode,
  output logic                                       mode_start,
  output logic [checker_pkg::word_width-1:0]         mode_addr,
  output logic                                       mode_ack,
  input  logic                                       mode_end,
  input  logic [checker_pkg::word_width-1:0]         mode_data,
  input  logic                                       mode_irq,
  input  logic                                       mode_error,
  // CPU interrupt
  output logic                                       irq,
  // Engine statistics
  input  logic [checker_pkg::stat_cpt_width-1:0]     stat_trn_cpt_tx,
  input  logic [checker_pkg::stat_cpt_width-1:0]     stat_trn_cpt_rx,
  input  logic [checker_pkg::stat_trn_width-1:0]     stat_trn
);
  import checker_pkg::*;

  checker_state_e              state;
  checker_csr_e                csr_reg;
  logic                        csr_selected;
  logic                        csr_wr;
  logic [csr_data_width-1:0]   csr_rdata;
  // Sticky events
  logic                        event_end;
  logic                        event_error;
  logic                        event_mode_irq;
  logic                        irq_en;

  // Block select in the top address bits
  assign csr_selected = (csr_a[csr_addr_width-1 -: 4] == csr_addr);
  assign csr_reg      = checker_csr_e'(csr_a[2:0]);
  assign csr_wr       = csr_selected && csr_we;

  // Any enabled event holds the line
  assign irq = irq_en && (event_end || event_error || event_mode_irq);

  // Read mux
  always_comb begin
    case (csr_reg)
      CSR_ADDRESS_LOW:    csr_rdata = mode_addr[31:0];
      CSR_ADDRESS_HIGH:   csr_rdata = mode_addr[63:32];
      CSR_STAT:           csr_rdata = csr_data_width'({event_mode_irq, event_error, event_end});
      CSR_CTRL:           csr_rdata = csr_data_width'({mode_start, mode_mode, irq_en});
      CSR_MODE_DATA_LOW:  csr_rdata = mode_data[31:0];
      CSR_MODE_DATA_HIGH: csr_rdata = mode_data[63:32];
      CSR_STAT_TRN_CPT:   csr_rdata = {stat_trn_cpt_rx, stat_trn_cpt_tx};
      default:            csr_rdata = stat_trn;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state          <= STATE_IDLE;
      csr_do         <= '0;
      mode_mode      <= MODE_SINGLE;
      mode_start     <= 1'b0;
      mode_addr      <= '0;
      mode_ack       <= 1'b0;
      event_end      <= 1'b0;
      event_error    <= 1'b0;
      event_mode_irq <= 1'b0;
      irq_en         <= 1'b0;
    end else begin
      // Ack is a single cycle pulse
      mode_ack <= 1'b0;

      // Run control
      case (state)
        STATE_IDLE: begin
          // Start bit written, engine sees it this cycle
          if (mode_start) begin
            state <= STATE_RUN;
          end
        end
        STATE_RUN: begin
          if (mode_end) begin
            state      <= STATE_IDLE;
            mode_start <= 1'b0;
            event_end  <= 1'b1;
          end else if (!mode_start) begin
            // Stopped by software, no event
            state <= STATE_IDLE;
          end else if (mode_error) begin
            state       <= STATE_IDLE;
            mode_start  <= 1'b0;
            event_error <= 1'b1;
          end else if (mode_irq) begin
            // Engine paused on a hit
            state          <= STATE_WAIT;
            event_mode_irq <= 1'b1;
          end
        end
        STATE_WAIT: begin
          if (!event_mode_irq) begin
            // Software cleared the hit
            state    <= STATE_ACK;
            mode_ack <= 1'b1;
          end else if (!mode_start) begin
            state          <= STATE_IDLE;
            event_mode_irq <= 1'b0;
          end
        end
        default: begin
          // ACK lasts one cycle
          state <= STATE_RUN;
        end
      endcase

      // Registered read data, zero outside the window
      csr_do <= csr_selected ? csr_rdata : '0;

      // Register writes win over the FSM updates above
      if (csr_wr) begin
        case (csr_reg)
          CSR_ADDRESS_LOW: begin
            if (state == STATE_IDLE) begin
              mode_addr[31:0] <= csr_di;
            end
          end
          CSR_ADDRESS_HIGH: begin
            if (state == STATE_IDLE) begin
              mode_addr[63:32] <= csr_di;
            end
          end
          CSR_STAT: begin
            // Write one to clear
            if (state == STATE_IDLE || state == STATE_WAIT) begin
              if (csr_di[0]) begin
                event_end <= 1'b0;
              end
              if (csr_di[1]) begin
                event_error <= 1'b0;
              end
              if (csr_di[2]) begin
                event_mode_irq <= 1'b0;
              end
            end
          end
          CSR_CTRL: begin
            if (state == STATE_IDLE) begin
              irq_en    <= csr_di[0];
              mode_mode <= checker_mode_e'(csr_di[2:1]);
            end
            // Start or stop at any time
            mode_start <= csr_di[3];
          end
          default: begin
            // Data and statistics are read only
          end
        endcase
      end
    end
  end

  // Ack only right after WAIT and never two cycles long
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    mode_ack |-> (state == STATE_ACK) && ($past(state) == STATE_WAIT) ##1 !mode_ack);

endmodule

/* source/checker_engine.sv */
module checker_engine #(
  parameter int          mem_words   = 256,
  parameter int          page_words  = 16,
  parameter int          mem_credits = 2,
  parameter logic [31:0] marker_tag  = 32'hc0de_f00d
) (
  input  logic                                    sys_clk,
  input  logic                                    sys_rst,
  // Mode port
  input  checker_pkg::checker_mode_e              mode_mode,
  input  logic                                    mode_start,
  input  logic [checker_pkg::word_width-1:0]      mode_addr,
  input  logic                                    mode_ack,
  output logic                                    mode_end,
  output logic                                    mode_error,
  output logic                                    mode_irq,
  output logic [checker_pkg::word_width-1:0]      mode_data,
  // Credited read port
  output logic                                    rd_req,
  output logic [$clog2(mem_words)-1:0]            rd_addr,
  output logic                                    rd_pop,
  input  logic                                    rd_valid,
  input  logic [checker_pkg::word_width-1:0]      rd_data,
  // Statistics
  output logic [checker_pkg::stat_cpt_width-1:0]  stat_trn_cpt_tx,
  output logic [checker_pkg::stat_cpt_width-1:0]  stat_trn_cpt_rx,
  output logic [checker_pkg::stat_trn_width-1:0]  stat_trn
);
  import checker_pkg::*;

  localparam int addr_w   = $clog2(mem_words);
  localparam int page_w   = $clog2(page_words);
  localparam int credit_w = $clog2(mem_credits + 1);

  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_SCAN,
    ENG_HOLD,
    ENG_DRAIN,
    ENG_DONE
  } engine_state_e;

  engine_state_e             state;
  logic [addr_w-1:0]         base;
  logic [stat_cpt_width-1:0] total;
  logic                      read_mode;
  logic [credit_w-1:0]       credits;
  logic                      addr_bad;
  logic                      tag_hit;
  logic [addr_w-1:0]         rx_addr;

  // Page or word address outside the array
  assign addr_bad = (mode_addr >= mem_words);
  assign tag_hit  = (rd_data[63:32] == marker_tag);

  // Requests run ahead while paused and pops wait for scan or drain
  assign rd_req  = (state == ENG_SCAN || state == ENG_HOLD) && (credits != '0) &&
                   (stat_trn_cpt_tx != total);
  assign rd_addr = base + stat_trn_cpt_tx[addr_w-1:0];
  assign rd_pop  = rd_valid && (state == ENG_SCAN || state == ENG_DRAIN);
  // Address of the word at the queue head
  assign rx_addr = base + stat_trn_cpt_rx[addr_w-1:0];

  // Credit pool
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      credits <= credit_w'(mem_credits);
    end else begin
      credits <= credits - credit_w'(rd_req) + credit_w'(rd_pop);
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state           <= ENG_IDLE;
      mode_end        <= 1'b0;
      mode_error      <= 1'b0;
      mode_irq        <= 1'b0;
      mode_data       <= '0;
      stat_trn_cpt_tx <= '0;
      stat_trn_cpt_rx <= '0;
      stat_trn        <= '0;
    end else begin
      mode_end   <= 1'b0;
      mode_error <= 1'b0;
      mode_irq   <= 1'b0;
      if (rd_req) begin
        stat_trn_cpt_tx <= stat_trn_cpt_tx + 1'b1;
      end
      if (rd_pop) begin
        stat_trn_cpt_rx <= stat_trn_cpt_rx + 1'b1;
      end

      case (state)
        ENG_IDLE: begin
          // Level start so a rise during a drain is caught here
          if (mode_start) begin
            stat_trn_cpt_tx <= '0;
            stat_trn_cpt_rx <= '0;
            stat_trn        <= '0;
            mode_data       <= '0;
            read_mode       <= (mode_mode == MODE_READ);
            state           <= ENG_SCAN;
            case (mode_mode)
              MODE_DUMMY: begin
                mode_end <= 1'b1;
                state    <= ENG_DONE;
              end
              MODE_AUTO: begin
                base  <= '0;
                total <= stat_cpt_width'(mem_words);
              end
              MODE_READ: begin
                base  <= mode_addr[addr_w-1:0];
                total <= stat_cpt_width'(1);
              end
              default: begin
                // Round down to the page
                base  <= {mode_addr[addr_w-1:page_w], {page_w{1'b0}}};
                total <= stat_cpt_width'(page_words);
              end
            endcase
            if (addr_bad && mode_mode != MODE_AUTO && mode_mode != MODE_DUMMY) begin
              mode_error <= 1'b1;
              state      <= ENG_DONE;
            end
          end
        end
        ENG_SCAN: begin
          if (!mode_start) begin
            state <= ENG_DRAIN;
          end else if (rd_pop) begin
            if (read_mode) begin
              mode_data <= rd_data;
            end else if (tag_hit) begin
              // Report the hit address and pause
              stat_trn  <= stat_trn + 1'b1;
              mode_data <= word_width'(rx_addr);
              mode_irq  <= 1'b1;
              state     <= ENG_HOLD;
            end
          end else if (stat_trn_cpt_rx == total) begin
            mode_end <= 1'b1;
            state    <= ENG_DONE;
          end
        end
        ENG_HOLD: begin
          if (!mode_start) begin
            state <= ENG_DRAIN;
          end else if (mode_ack) begin
            state <= ENG_SCAN;
          end
        end
        ENG_DRAIN: begin
          // Discard until every credit is home
          if (credits == credit_w'(mem_credits)) begin
            state <= ENG_IDLE;
          end
        end
        default: begin
          // Wait for the controller to drop start
          if (!mode_start) begin
            state <= ENG_IDLE;
          end
        end
      endcase
    end
  end

  // Pool never overflows
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    credits <= credit_w'(mem_credits));

  // Outstanding reads stay below the credit limit when a request goes out
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    rd_req |-> (stat_trn_cpt_tx - stat_trn_cpt_rx) < stat_cpt_width'(mem_credits));

endmodule

/* source/checker_mem.sv */
module checker_mem #(
  parameter int mem_words   = 256,
  parameter int mem_credits = 2
) (
  input  logic                                sys_clk,
  input  logic                                sys_rst,
  // Load port
  input  logic                                ld_en,
  input  logic [$clog2(mem_words)-1:0]        ld_addr,
  input  logic [checker_pkg::word_width-1:0]  ld_data,
  // Credited read port
  input  logic                                rd_req,
  input  logic [$clog2(mem_words)-1:0]        rd_addr,
  input  logic                                rd_pop,
  output logic                                rd_valid,
  output logic [checker_pkg::word_width-1:0]  rd_data
);
  import checker_pkg::*;

  localparam int ptr_w = (mem_credits > 1) ? $clog2(mem_credits) : 1;
  localparam int cnt_w = $clog2(mem_credits + 1);

  logic [word_width-1:0] mem   [mem_words];
  logic [word_width-1:0] queue [mem_credits];
  logic [ptr_w-1:0]      wr_ptr;
  logic [ptr_w-1:0]      rd_ptr;
  logic [cnt_w-1:0]      count;

  // Ring pointer step
  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(mem_credits - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Load write port
  always_ff @(posedge sys_clk) begin
    if (ld_en) begin
      mem[ld_addr] <= ld_data;
    end
  end

  // Array read lands straight in the response slot
  always_ff @(posedge sys_clk) begin
    if (rd_req) begin
      queue[wr_ptr] <= mem[rd_addr];
    end
  end

  // Queue bookkeeping
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (rd_req) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (rd_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      count <= count + cnt_w'(rd_req) - cnt_w'(rd_pop);
    end
  end

  assign rd_valid = (count != '0);
  assign rd_data  = queue[rd_ptr];

  // Credits keep a slot free for every request
  assert property (@(posedge sys_clk) disable iff (sys_rst)
    rd_req |-> count != cnt_w'(mem_credits));

  assert property (@(posedge sys_clk) disable iff (sys_rst)
    rd_pop |-> count != '0);

endmodule

/* source/checker_top.sv */
module checker_top #(
  parameter logic [3:0]  csr_addr    = 4'h0,
  parameter int          mem_words   = 256,
  parameter int          page_words  = 16,
  parameter int          mem_credits = 2,
  parameter logic [31:0] marker_tag  = 32'hc0de_f00d
) (
  input  logic                                    sys_clk,
  input  logic                                    sys_rst,
  // CSR port
  input  logic [checker_pkg::csr_addr_width-1:0]  csr_a,
  input  logic                                    csr_we,
  input  logic [checker_pkg::csr_data_width-1:0]  csr_di,
  output logic [checker_pkg::csr_data_width-1:0]  csr_do,
  output logic                                    irq,
  // Memory load port
  input  logic                                    ld_en,
  input  logic [$clog2(mem_words)-1:0]            ld_addr,
  input  logic [checker_pkg::word_width-1:0]      ld_data
);
  import checker_pkg::*;

  // Controller to engine
  checker_mode_e               mode_mode;
  logic                        mode_start;
  logic [word_width-1:0]       mode_addr;
  logic                        mode_ack;
  logic                        mode_end;
  logic                        mode_error;
  logic                        mode_irq;
  logic [word_width-1:0]       mode_data;
  logic [stat_cpt_width-1:0]   stat_trn_cpt_tx;
  logic [stat_cpt_width-1:0]   stat_trn_cpt_rx;
  logic [stat_trn_width-1:0]   stat_trn;
  // Engine to memory
  logic                        rd_req;
  logic [$clog2(mem_words)-1:0] rd_addr;
  logic                        rd_pop;
  logic                        rd_valid;
  logic [word_width-1:0]       rd_data;

  checker_ctlif #(
    .csr_addr (csr_addr)
  ) ctlif_i (
    .sys_clk, .sys_rst, .csr_a, .csr_we, .csr_di, .csr_do,
    .mode_mode, .mode_start, .mode_addr, .mode_ack,
    .mode_end, .mode_data, .mode_irq, .mode_error, .irq,
    .stat_trn_cpt_tx, .stat_trn_cpt_rx, .stat_trn
  );

  checker_engine #(
    .mem_words   (mem_words),
    .page_words  (page_words),
    .mem_credits (mem_credits),
    .marker_tag  (marker_tag)
  ) engine_i (
    .sys_clk, .sys_rst, .mode_mode, .mode_start, .mode_addr, .mode_ack,
    .mode_end, .mode_error, .mode_irq, .mode_data,
    .rd_req, .rd_addr, .rd_pop, .rd_valid, .rd_data,
    .stat_trn_cpt_tx, .stat_trn_cpt_rx, .stat_trn
  );

  checker_mem #(
    .mem_words   (mem_words),
    .mem_credits (mem_credits)
  ) mem_i (
    .sys_clk, .sys_rst, .ld_en, .ld_addr, .ld_data,
    .rd_req, .rd_addr, .rd_pop, .rd_valid, .rd_data
  );

endmodule

/* tests/checker_tb.sv */
module checker_tb;
  import checker_pkg::*;

  localparam logic [3:0]  csr_blk     = 4'h5;
  localparam int          mem_words   = 256;
  localparam int          page_words  = 16;
  localparam int          mem_credits = 2;
  localparam logic [31:0] marker_tag  = 32'hc0de_f00d;
  localparam int          addr_w      = $clog2(mem_words);
  // Cycles allowed for any single wait on irq
  localparam int          wait_limit  = 2000;

  logic                        sys_clk;
  logic                        sys_rst;
  logic [csr_addr_width-1:0]   csr_a;
  logic                        csr_we;
  logic [csr_data_width-1:0]   csr_di;
  logic [csr_data_width-1:0]   csr_do;
  logic                        irq;
  logic                        ld_en;
  logic [addr_w-1:0]           ld_addr;
  logic [word_width-1:0]       ld_data;

  // Copy of the DUT memory
  logic [word_width-1:0]       shadow [mem_words];
  int                          exp_hits [$];
  // Pending read compare
  bit                          check_pending;
  logic [csr_data_width-1:0]   check_value;
  string                       check_name;

  checker_top #(
    .csr_addr    (csr_blk),
    .mem_words   (mem_words),
    .page_words  (page_words),
    .mem_credits (mem_credits),
    .marker_tag  (marker_tag)
  ) dut_i (
    .sys_clk (sys_clk),
    .sys_rst (sys_rst),
    .csr_a   (csr_a),
    .csr_we  (csr_we),
    .csr_di  (csr_di),
    .csr_do  (csr_do),
    .irq     (irq),
    .ld_en   (ld_en),
    .ld_addr (ld_addr),
    .ld_data (ld_data)
  );

  always #20 sys_clk = ~sys_clk;

  // Expected hits, word count and error for one run
  function automatic int reference_scan(input checker_mode_e mode, input logic [63:0] addr,
                                        output int scanned, output bit err);
    int first;
    exp_hits.delete();
    first   = 0;
    scanned = 0;
    err     = (mode == MODE_SINGLE || mode == MODE_READ) && (addr >= 64'(mem_words));
    if (!err) begin
      case (mode)
        MODE_SINGLE: begin
          first   = int'(addr) / page_words * page_words;
          scanned = page_words;
        end
        MODE_AUTO: begin
          scanned = mem_words;
        end
        MODE_READ: begin
          first   = int'(addr);
          scanned = 1;
        end
        default: begin
          scanned = 0;
        end
      endcase
    end
    // Only the scan modes look for tags
    if (mode == MODE_SINGLE || mode == MODE_AUTO) begin
      for (int i = first; i < first + scanned; i++) begin
        if (shadow[i][63:32] == marker_tag) begin
          exp_hits.push_back(i);
        end
      end
    end
    return exp_hits.size();
  endfunction

  function automatic logic [csr_addr_width-1:0] csr_address(input checker_csr_e idx);
    return {csr_blk, 7'd0, idx};
  endfunction

  // Read data compare once csr_do has settled after the rising edge
  always @(negedge sys_clk) begin
    if (check_pending) begin
      check_pending = 1'b0;
      assert (csr_do === check_value) else begin
        $display("error at %0t: %s read 0x%08h, expected 0x%08h",
                 $time, check_name, csr_do, check_value);
        $display("Simulation finished: FAIL");
        $fatal(1, "CSR read mismatch");
      end
    end
  end

  // All tasks enter and leave on a falling edge
  task automatic write_csr(input checker_csr_e idx, input logic [31:0] value);
    csr_a  = csr_address(idx);
    csr_di = value;
    csr_we = 1'b1;
    @(negedge sys_clk);
    csr_we = 1'b0;
  endtask

  task automatic expect_csr(input checker_csr_e idx, input logic [31:0] value);
    csr_a  = csr_address(idx);
    csr_we = 1'b0;
    @(posedge sys_clk);
    check_name    = idx.name();
    check_value   = value;
    check_pending = 1'b1;
    @(negedge sys_clk);
  endtask

  task automatic load_word(input int addr, input logic [63:0] value);
    shadow[addr] = value;
    ld_en   = 1'b1;
    ld_addr = addr_w'(addr);
    ld_data = value;
    @(negedge sys_clk);
    ld_en = 1'b0;
  endtask

  task automatic wait_irq(input int limit);
    int waited;
    waited = 0;
    while (!irq) begin
      @(negedge sys_clk);
      waited++;
      assert (waited < limit) else begin
        $display("The checker never signalled an interrupt within %0d cycles", limit);
        $display("Simulation finished: FAIL");
        $fatal(1, "interrupt timeout");
      end
    end
  endtask

  // Address first and then mode with irq enable and start
  task automatic start_run(input checker_mode_e mode, input logic [63:0] addr);
    write_csr(CSR_ADDRESS_LOW, addr[31:0]);
    write_csr(CSR_ADDRESS_HIGH, addr[63:32]);
    write_csr(CSR_CTRL, {28'd0, 1'b1, mode, 1'b1});
  endtask

  task automatic run_dummy();
    int hits;
    int scanned;
    bit err;
    hits = reference_scan(MODE_DUMMY, 64'd0, scanned, err);
    start_run(MODE_DUMMY, 64'd0);
    wait_irq(wait_limit);
    expect_csr(CSR_STAT, 32'h1);
    expect_csr(CSR_STAT_TRN, 32'(hits));
    expect_csr(CSR_STAT_TRN_CPT, {16'(scanned), 16'(scanned)});
    write_csr(CSR_STAT, 32'h1);
    assert (!irq) else begin
      $display("The interrupt stayed high after the end event was cleared");
      $display("Simulation finished: FAIL");
      $fatal(1, "irq stuck");
    end
    // Start bit dropped by the controller
    expect_csr(CSR_CTRL, {28'd0, 1'b0, MODE_DUMMY, 1'b1});
  endtask

  task automatic run_read(input logic [63:0] addr);
    int scanned;
    bit err;
    void'(reference_scan(MODE_READ, addr, scanned, err));
    start_run(MODE_READ, addr);
    wait_irq(wait_limit);
    if (err) begin
      expect_csr(CSR_STAT, 32'h2);
      expect_csr(CSR_STAT_TRN_CPT, 32'h0);
      write_csr(CSR_STAT, 32'h2);
    end else begin
      expect_csr(CSR_STAT, 32'h1);
      expect_csr(CSR_MODE_DATA_LOW, shadow[int'(addr)][31:0]);
      expect_csr(CSR_MODE_DATA_HIGH, shadow[int'(addr)][63:32]);
      expect_csr(CSR_STAT_TRN_CPT, {16'(scanned), 16'(scanned)});
      write_csr(CSR_STAT, 32'h1);
    end
  endtask

  task automatic run_scan(input checker_mode_e mode, input logic [63:0] addr, input bit slow_ack);
    int hits;
    int scanned;
    bit err;
    hits = reference_scan(mode, addr, scanned, err);
    start_run(mode, addr);
    for (int i = 0; i < hits; i++) begin
      wait_irq(wait_limit);
      expect_csr(CSR_STAT, 32'h4);
      expect_csr(CSR_MODE_DATA_LOW, 32'(exp_hits[i]));
      expect_csr(CSR_MODE_DATA_HIGH, 32'h0);
      if (mode == MODE_AUTO && i == 0) begin
        // Address locked while paused
        write_csr(CSR_ADDRESS_LOW, ~addr[31:0]);
        expect_csr(CSR_ADDRESS_LOW, addr[31:0]);
      end
      if (slow_ack) begin
        repeat ($urandom_range(0, 20)) @(negedge sys_clk);
      end
      // Clearing the hit resumes the scan
      write_csr(CSR_STAT, 32'h4);
    end
    wait_irq(wait_limit);
    expect_csr(CSR_STAT, 32'h1);
    expect_csr(CSR_STAT_TRN, 32'(hits));
    expect_csr(CSR_STAT_TRN_CPT, {16'(scanned), 16'(scanned)});
    write_csr(CSR_STAT, 32'h1);
  endtask

  initial begin
    logic [63:0] word;
    logic [31:0] lo;
    logic [31:0] hi;
    int          page_base;
    sys_clk       = 1'b0;
    sys_rst       = 1'b1;
    csr_a         = '0;
    csr_we        = 1'b0;
    csr_di        = '0;
    ld_en         = 1'b0;
    ld_addr       = '0;
    ld_data       = '0;
    check_pending = 1'b0;
    void'($urandom(32'h9a60_4125));
    repeat (8) @(negedge sys_clk);
    sys_rst = 1'b0;

    // Idle after reset
    expect_csr(CSR_CTRL, 32'h0);
    expect_csr(CSR_STAT, 32'h0);

    // Random fill with tags at both ends and scattered
    for (int i = 0; i < mem_words; i++) begin
      word = {$urandom, $urandom};
      if (i == 0 || i == mem_words - 1 || $urandom_range(0, 19) == 0) begin
        word[63:32] = marker_tag;
      end
      load_word(i, word);
    end
    // Page 3 gets first, back to back and last word hits
    page_base = 3 * page_words;
    load_word(page_base, {marker_tag, $urandom});
    load_word(page_base + 5, {marker_tag, $urandom});
    load_word(page_base + 6, {marker_tag, $urandom});
    load_word(page_base + page_words - 1, {marker_tag, $urandom});

    // Register read back while idle
    lo = $urandom;
    hi = $urandom;
    write_csr(CSR_ADDRESS_LOW, lo);
    write_csr(CSR_ADDRESS_HIGH, hi);
    write_csr(CSR_CTRL, {28'd0, 1'b0, MODE_AUTO, 1'b1});
    expect_csr(CSR_ADDRESS_LOW, lo);
    expect_csr(CSR_ADDRESS_HIGH, hi);
    expect_csr(CSR_CTRL, 32'h3);

    run_dummy();

    // Quad word reads and then out of range addresses
    repeat (4) begin
      run_read(64'($urandom_range(0, mem_words - 1)));
    end
    run_read(64'(mem_words + $urandom_range(0, 100)));
    run_read({32'h1, 32'h10});

    run_scan(MODE_SINGLE, 64'(page_base + 7), 1'b0);
    run_scan(MODE_SINGLE, 64'($urandom_range(0, mem_words - 1)), 1'b0);
    run_scan(MODE_AUTO, 64'h7, 1'b1);

    // Stop an AUTO run while it waits on the first hit
    start_run(MODE_AUTO, 64'h0);
    wait_irq(wait_limit);
    expect_csr(CSR_STAT, 32'h4);
    write_csr(CSR_CTRL, {28'd0, 1'b0, MODE_AUTO, 1'b1});
    expect_csr(CSR_CTRL, 32'h3);
    repeat (40) begin
      assert (!irq) else begin
        $display("An event was raised after the run was stopped");
        $display("Simulation finished: FAIL");
        $fatal(1, "event after stop");
      end
      @(negedge sys_clk);
    end
    expect_csr(CSR_STAT, 32'h0);
    // Engine drained so the next run still works
    run_dummy();

    repeat (2) @(negedge sys_clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* vlog.f */
source/checker_pkg.sv
source/checker_ctlif.sv
source/checker_engine.sv
source/checker_mem.sv
source/checker_top.sv
tests/checker_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= checker_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
